// ==== hdl/cpuIsaPkg.sv ====
`default_nettype none

package cpuIsaPkg;

    // Machine word, shared by data and instructions
    typedef logic [31:0] wordT;

    // Register file index
    typedef logic [4:0] regIdxT;

    localparam int NUM_REGS = 32;

    // All-ones word stops the machine
    localparam wordT HALT_WORD = 32'hffff_ffff;

    // Instruction field positions
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_MSB    = 25;
    localparam int RS_LSB    = 21;
    localparam int RT_MSB    = 20;
    localparam int RT_LSB    = 16;
    localparam int RD_MSB    = 15;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_MSB = 10;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_MSB = 5;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_MSB   = 15;
    localparam int IMM_LSB   = 0;

    // Major opcodes, MIPS encoding
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b,
        opHalt  = 6'h3f
    } opcodeE;

    // R-type function codes
    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

endpackage

`default_nettype wire

// ==== hdl/cpuPipePkg.sv ====
`default_nettype none

package cpuPipePkg;

    // Run controller states
    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stDrain,
        stHalted
    } runStateE;

    // ALU functions; aluEq and aluNe give 1 or 0 for branches
    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluEq,
        aluNe
    } aluOpE;

    // Operand source for the ALU inputs
    typedef enum logic [1:0] {
        fwdReg,
        fwdExMem,
        fwdMemWb
    } fwdSelE;

endpackage

`default_nettype wire

// ==== hdl/drainTimer.sv ====
`default_nettype none

module drainTimer #(
    parameter int DRAIN_CYCLES = 3
) (
    input  wire logic idex,
    input  wire logic rstN,
    input  wire logic load,
    output logic      done
);

    localparam int CNT_W = $clog2(DRAIN_CYCLES + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge idex) begin
        if (!rstN) begin
            count <= '0;
        end else if (load) begin
            count <= CNT_W'(DRAIN_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // High in the last cycle before the count hits zero
    assign done = (count == CNT_W'(1));

endmodule

`default_nettype wire

// ==== hdl/runControl.sv ====
`default_nettype none

module runControl import cpuPipePkg::*; #(
    parameter int DRAIN_CYCLES = 3
) (
    input  wire logic idex,
    input  wire logic rstN,
    input  wire logic start,
    input  wire logic haltSeen,
    output logic      fetchEn,
    output logic      pcClear,
    output logic      progEn,
    output logic      halted
);

    runStateE state;
    runStateE stateNext;
    logic     drainLoad;
    logic     drainDone;

    always_ff @(posedge idex) begin
        if (!rstN) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle:   if (start) stateNext = stRun;
            stRun:    if (haltSeen) stateNext = stDrain;
            stDrain:  if (drainDone) stateNext = stHalted;
            // Only reset leaves halted
            default:  stateNext = stHalted;
        endcase
    end

    // Start also points the pc back at word 0
    assign pcClear   = (state == stIdle) && start;
    assign progEn    = (state == stIdle);
    assign halted    = (state == stHalted);
    // Timer armed on the halt itself
    assign drainLoad = (state == stRun) && haltSeen;
    // Fetch stops the same edge the halt leaves decode
    assign fetchEn   = (state == stRun) && !haltSeen;

    drainTimer #(
        .DRAIN_CYCLES(DRAIN_CYCLES)
    ) drainTimer_i (
        .idex (idex),
        .rstN (rstN),
        .load (drainLoad),
        .done (drainDone)
    );

endmodule

`default_nettype wire

// ==== hdl/fetchStage.sv ====
`default_nettype none

module fetchStage import cpuIsaPkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire logic                          idex,
    input  wire logic                          rstN,
    input  wire logic                          fetchEn,
    input  wire logic                          pcClear,
    input  wire logic                          stall,
    input  wire logic                          branchTaken,
    input  wire wordT                          branchTarget,
    input  wire logic                          progWe,
    input  wire logic                          progEn,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] progAddr,
    input  wire wordT                          progData,
    output wordT                               ifInstr,
    output wordT                               ifPcNext,
    output logic                               ifValid
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    wordT imem [IMEM_DEPTH];
    wordT pc;
    wordT pcInc;
    logic advance;

    // Word addressing, so next pc is plain +1
    assign pcInc   = pc + 32'd1;
    assign advance = fetchEn && !stall && !branchTaken && !pcClear;

    // Load port, open only while the machine is idle
    always_ff @(posedge idex) begin
        if (progWe && progEn) begin
            imem[progAddr] <= progData;
        end
    end

    // Priority is clear, redirect, stop, stall hold, then step
    always_ff @(posedge idex) begin
        if (!rstN) begin
            pc      <= '0;
            ifValid <= 1'b0;
        end else if (pcClear) begin
            pc      <= '0;
            ifValid <= 1'b0;
        end else if (branchTaken) begin
            pc      <= branchTarget;
            ifValid <= 1'b0;
        end else if (!fetchEn) begin
            // Nothing new enters decode once fetch stops
            ifValid <= 1'b0;
        end else if (!stall) begin
            pc      <= pcInc;
            ifValid <= 1'b1;
        end
    end

    always_ff @(posedge idex) begin
        if (advance) begin
            ifInstr  <= imem[pc[IMEM_AW-1:0]];
            ifPcNext <= pcInc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`default_nettype none

module decodeStage import cpuIsaPkg::*; import cpuPipePkg::*; (
    input  wire logic   idex,
    input  wire logic   rstN,
    input  wire wordT   ifInstr,
    input  wire wordT   ifPcNext,
    input  wire logic   ifValid,
    input  wire logic   stall,
    input  wire logic   branchTaken,
    input  wire logic   wbValid,
    input  wire regIdxT wbReg,
    input  wire wordT   wbData,
    output logic        haltSeen,
    output regIdxT      idRs,
    output regIdxT      idRt,
    output regIdxT      exRs,
    output regIdxT      exRt,
    output regIdxT      exDest,
    output logic        exRegWrite,
    output logic        exMemRead,
    output logic        exMemWrite,
    output logic        exBranchOp,
    output aluOpE       exAluOp,
    output logic        exUseImm,
    output logic [4:0]  exShamt,
    output wordT        exImm,
    output wordT        exPcNext,
    output wordT        exValA,
    output wordT        exValB
);

    wordT   regs [NUM_REGS];
    opcodeE op;
    functE  fn;
    regIdxT idRd;
    wordT   immExt;
    wordT   rdA;
    wordT   rdB;
    logic   bubble;

    // Decoded controls
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branchOp;
    logic  useImm;
    logic  useRd;
    aluOpE aluOp;

    assign op     = opcodeE'(ifInstr[OP_MSB:OP_LSB]);
    assign fn     = functE'(ifInstr[FUNCT_MSB:FUNCT_LSB]);
    assign idRs   = ifInstr[RS_MSB:RS_LSB];
    assign idRt   = ifInstr[RT_MSB:RT_LSB];
    assign idRd   = ifInstr[RD_MSB:RD_LSB];
    assign immExt = {{16{ifInstr[IMM_MSB]}}, ifInstr[IMM_MSB:IMM_LSB]};

    // Empty slot, load-use hold or squash by a taken branch
    assign bubble = !ifValid || stall || branchTaken;

    // Halt reported once; it then moves on as a bubble
    assign haltSeen = ifValid && !stall && !branchTaken && (ifInstr == HALT_WORD);

    always_comb begin
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        branchOp = 1'b0;
        useImm   = 1'b0;
        useRd    = 1'b0;
        aluOp    = aluAdd;
        case (op)
            opRType: begin
                useRd    = 1'b1;
                regWrite = 1'b1;
                case (fn)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    fnSll:   aluOp = aluSll;
                    // Unknown funct acts as a nop
                    default: regWrite = 1'b0;
                endcase
            end
            opAddi: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
            end
            opLw: begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                useImm   = 1'b1;
            end
            opSw: begin
                memWrite = 1'b1;
                useImm   = 1'b1;
            end
            opBeq: begin
                branchOp = 1'b1;
                aluOp    = aluEq;
            end
            opBne: begin
                branchOp = 1'b1;
                aluOp    = aluNe;
            end
            // Halt and anything unknown write nothing
            default: regWrite = 1'b0;
        endcase
    end

    // Register file, write-first; r0 is never written so stays 0
    always_ff @(posedge idex) begin
        if (!rstN) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbReg] <= wbData;
        end
    end

    assign rdA = (wbValid && wbReg == idRs) ? wbData : regs[idRs];
    assign rdB = (wbValid && wbReg == idRt) ? wbData : regs[idRt];

    // Decode/execute controls
    always_ff @(posedge idex) begin
        if (!rstN || bubble) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
            exBranchOp <= 1'b0;
            exDest     <= '0;
        end else begin
            exRegWrite <= regWrite;
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
            exBranchOp <= branchOp;
            exDest     <= useRd ? idRd : idRt;
        end
    end

    // Operand payload
    always_ff @(posedge idex) begin
        exRs     <= idRs;
        exRt     <= idRt;
        exAluOp  <= aluOp;
        exUseImm <= useImm;
        exShamt  <= ifInstr[SHAMT_MSB:SHAMT_LSB];
        exImm    <= immExt;
        exPcNext <= ifPcNext;
        exValA   <= rdA;
        exValB   <= rdB;
    end

endmodule

`default_nettype wire

// ==== hdl/hazardUnit.sv ====
`default_nettype none

module hazardUnit import cpuIsaPkg::*; import cpuPipePkg::*; (
    input  wire regIdxT idRs,
    input  wire regIdxT idRt,
    input  wire regIdxT exRs,
    input  wire regIdxT exRt,
    input  wire logic   exMemRead,
    input  wire regIdxT exDest,
    input  wire regIdxT memDest,
    input  wire logic   memRegWrite,
    input  wire regIdxT wbDest,
    input  wire logic   wbRegWrite,
    output fwdSelE      fwdA,
    output fwdSelE      fwdB,
    output logic        stall
);

    // Source for one operand; the younger result wins
    function automatic fwdSelE pickSource(
        regIdxT src,
        regIdxT exMemDest,
        logic   exMemWr,
        regIdxT memWbDest,
        logic   memWbWr
    );
        pickSource = fwdReg;
        // r0 reads as zero, nothing to forward
        if (src != '0) begin
            if (exMemWr && exMemDest == src) begin
                pickSource = fwdExMem;
            end else if (memWbWr && memWbDest == src) begin
                pickSource = fwdMemWb;
            end
        end
    endfunction

    assign fwdA = pickSource(exRs, memDest, memRegWrite, wbDest, wbRegWrite);
    assign fwdB = pickSource(exRt, memDest, memRegWrite, wbDest, wbRegWrite);

    // Load in execute feeding decode costs one bubble
    assign stall = exMemRead && (exDest != '0) && (exDest == idRs || exDest == idRt);

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`default_nettype none

module executeStage import cpuIsaPkg::*; import cpuPipePkg::*; (
    input  wire logic       idex,
    input  wire logic       rstN,
    input  wire fwdSelE     fwdA,
    input  wire fwdSelE     fwdB,
    input  wire regIdxT     exDest,
    input  wire logic       exRegWrite,
    input  wire logic       exMemRead,
    input  wire logic       exMemWrite,
    input  wire logic       exBranchOp,
    input  wire aluOpE      exAluOp,
    input  wire logic       exUseImm,
    input  wire logic [4:0] exShamt,
    input  wire wordT       exImm,
    input  wire wordT       exPcNext,
    input  wire wordT       exValA,
    input  wire wordT       exValB,
    input  wire wordT       wbData,
    output logic            branchTaken,
    output wordT            branchTarget,
    output wordT            memAlu,
    output wordT            memStoreVal,
    output regIdxT          memDest,
    output logic            memRegWrite,
    output logic            memMemRead,
    output logic            memMemWrite
);

    wordT opA;
    wordT opB;
    wordT aluB;
    wordT aluRes;

    // Forwarding mux shared by both operands
    function automatic wordT pickOperand(
        fwdSelE sel,
        wordT   regVal,
        wordT   exMemVal,
        wordT   memWbVal
    );
        case (sel)
            fwdExMem: pickOperand = exMemVal;
            fwdMemWb: pickOperand = memWbVal;
            default:  pickOperand = regVal;
        endcase
    endfunction

    assign opA  = pickOperand(fwdA, exValA, memAlu, wbData);
    assign opB  = pickOperand(fwdB, exValB, memAlu, wbData);
    // Immediate replaces rt for addi, lw and sw
    assign aluB = exUseImm ? exImm : opB;

    always_comb begin
        case (exAluOp)
            aluAdd:  aluRes = opA + aluB;
            aluSub:  aluRes = opA - aluB;
            aluAnd:  aluRes = opA & aluB;
            aluOr:   aluRes = opA | aluB;
            aluSlt:  aluRes = {31'b0, $signed(opA) < $signed(aluB)};
            // sll shifts rt, rs unused
            aluSll:  aluRes = aluB << exShamt;
            aluEq:   aluRes = {31'b0, opA == aluB};
            aluNe:   aluRes = {31'b0, opA != aluB};
            default: aluRes = '0;
        endcase
    end

    // Compare result bit decides the branch
    assign branchTaken  = exBranchOp && aluRes[0];
    // Relative to the instruction after the branch
    assign branchTarget = exPcNext + exImm;

    // Execute/memory controls
    always_ff @(posedge idex) begin
        if (!rstN) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
            memDest     <= '0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
            memDest     <= exDest;
        end
    end

    // Store data carries the forwarded rt
    always_ff @(posedge idex) begin
        memAlu      <= aluRes;
        memStoreVal <= opB;
    end

endmodule

`default_nettype wire

// ==== hdl/memoryStage.sv ====
`default_nettype none

module memoryStage import cpuIsaPkg::*; #(
    parameter int DMEM_DEPTH = 64
) (
    input  wire logic   idex,
    input  wire logic   rstN,
    input  wire wordT   memAlu,
    input  wire wordT   memStoreVal,
    input  wire regIdxT memDest,
    input  wire logic   memRegWrite,
    input  wire logic   memMemRead,
    input  wire logic   memMemWrite,
    output logic        wbValid,
    output regIdxT      wbReg,
    output regIdxT      wbDest,
    output logic        wbRegWrite,
    output wordT        wbData
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    wordT               dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] addr;

    // Word addressed, upper address bits ignored
    assign addr = memAlu[DMEM_AW-1:0];

    always_ff @(posedge idex) begin
        if (memMemWrite) begin
            dmem[addr] <= memStoreVal;
        end
    end

    // Write-back controls
    always_ff @(posedge idex) begin
        if (!rstN) begin
            wbRegWrite <= 1'b0;
            wbValid    <= 1'b0;
            wbDest     <= '0;
        end else begin
            wbRegWrite <= memRegWrite;
            // r0 writes retire silently
            wbValid    <= memRegWrite && (memDest != '0);
            wbDest     <= memDest;
        end
    end

    // Load data or ALU result
    always_ff @(posedge idex) begin
        wbData <= memMemRead ? dmem[addr] : memAlu;
    end

    assign wbReg = wbDest;

endmodule

`default_nettype wire

// ==== hdl/cpuTop.sv ====
`default_nettype none

module cpuTop import cpuIsaPkg::*; import cpuPipePkg::*; #(
    parameter int IMEM_DEPTH   = 64,
    parameter int DMEM_DEPTH   = 64,
    parameter int DRAIN_CYCLES = 3
) (
    input  wire logic                          idex,
    input  wire logic                          rstN,
    input  wire logic                          progWe,
    input  wire logic [$clog2(IMEM_DEPTH)-1:0] progAddr,
    input  wire wordT                          progData,
    input  wire logic                          start,
    output logic                               wbValid,
    output regIdxT                             wbReg,
    output wordT                               wbData,
    output logic                               halted
);

    // Run control
    logic fetchEn;
    logic pcClear;
    logic progEn;
    logic haltSeen;

    // Fetch/decode register
    wordT ifInstr;
    wordT ifPcNext;
    logic ifValid;

    // Hazard and redirect
    logic   stall;
    logic   branchTaken;
    wordT   branchTarget;
    fwdSelE fwdA;
    fwdSelE fwdB;

    // Decode/execute register
    regIdxT     idRs;
    regIdxT     idRt;
    regIdxT     exRs;
    regIdxT     exRt;
    regIdxT     exDest;
    logic       exRegWrite;
    logic       exMemRead;
    logic       exMemWrite;
    logic       exBranchOp;
    aluOpE      exAluOp;
    logic       exUseImm;
    logic [4:0] exShamt;
    wordT       exImm;
    wordT       exPcNext;
    wordT       exValA;
    wordT       exValB;

    // Execute/memory register
    wordT   memAlu;
    wordT   memStoreVal;
    regIdxT memDest;
    logic   memRegWrite;
    logic   memMemRead;
    logic   memMemWrite;

    // Memory/write-back register, forwarding side
    regIdxT wbDest;
    logic   wbRegWrite;

    runControl #(
        .DRAIN_CYCLES(DRAIN_CYCLES)
    ) runControl_i (
        .idex     (idex),
        .rstN     (rstN),
        .start    (start),
        .haltSeen (haltSeen),
        .fetchEn  (fetchEn),
        .pcClear  (pcClear),
        .progEn   (progEn),
        .halted   (halted)
    );

    fetchStage #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) fetchStage_i (
        .idex         (idex),
        .rstN         (rstN),
        .fetchEn      (fetchEn),
        .pcClear      (pcClear),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .progWe       (progWe),
        .progEn       (progEn),
        .progAddr     (progAddr),
        .progData     (progData),
        .ifInstr      (ifInstr),
        .ifPcNext     (ifPcNext),
        .ifValid      (ifValid)
    );

    decodeStage decodeStage_i (
        .idex        (idex),
        .rstN        (rstN),
        .ifInstr     (ifInstr),
        .ifPcNext    (ifPcNext),
        .ifValid     (ifValid),
        .stall       (stall),
        .branchTaken (branchTaken),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData),
        .haltSeen    (haltSeen),
        .idRs        (idRs),
        .idRt        (idRt),
        .exRs        (exRs),
        .exRt        (exRt),
        .exDest      (exDest),
        .exRegWrite  (exRegWrite),
        .exMemRead   (exMemRead),
        .exMemWrite  (exMemWrite),
        .exBranchOp  (exBranchOp),
        .exAluOp     (exAluOp),
        .exUseImm    (exUseImm),
        .exShamt     (exShamt),
        .exImm       (exImm),
        .exPcNext    (exPcNext),
        .exValA      (exValA),
        .exValB      (exValB)
    );

    hazardUnit hazardUnit_i (
        .idRs        (idRs),
        .idRt        (idRt),
        .exRs        (exRs),
        .exRt        (exRt),
        .exMemRead   (exMemRead),
        .exDest      (exDest),
        .memDest     (memDest),
        .memRegWrite (memRegWrite),
        .wbDest      (wbDest),
        .wbRegWrite  (wbRegWrite),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .stall       (stall)
    );

    executeStage executeStage_i (
        .idex         (idex),
        .rstN         (rstN),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .exDest       (exDest),
        .exRegWrite   (exRegWrite),
        .exMemRead    (exMemRead),
        .exMemWrite   (exMemWrite),
        .exBranchOp   (exBranchOp),
        .exAluOp      (exAluOp),
        .exUseImm     (exUseImm),
        .exShamt      (exShamt),
        .exImm        (exImm),
        .exPcNext     (exPcNext),
        .exValA       (exValA),
        .exValB       (exValB),
        .wbData       (wbData),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .memAlu       (memAlu),
        .memStoreVal  (memStoreVal),
        .memDest      (memDest),
        .memRegWrite  (memRegWrite),
        .memMemRead   (memMemRead),
        .memMemWrite  (memMemWrite)
    );

    memoryStage #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) memoryStage_i (
        .idex        (idex),
        .rstN        (rstN),
        .memAlu      (memAlu),
        .memStoreVal (memStoreVal),
        .memDest     (memDest),
        .memRegWrite (memRegWrite),
        .memMemRead  (memMemRead),
        .memMemWrite (memMemWrite),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbDest      (wbDest),
        .wbRegWrite  (wbRegWrite),
        .wbData      (wbData)
    );

endmodule

`default_nettype wire

// ==== sim/cpuTests.svh ====
`ifndef CPU_TESTS_SVH
`define CPU_TESTS_SVH

// R-type encoding
function automatic wordT encR(functE fn, regIdxT rs, regIdxT rt, regIdxT rd,
                              logic [4:0] shamt);
    return {opRType, rs, rt, rd, shamt, fn};
endfunction

// I-type encoding; imm is the raw 16-bit field
function automatic wordT encI(opcodeE op, regIdxT rs, regIdxT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic expectWb(regIdxT r, wordT d);
    expReg.push_back(r);
    expData.push_back(d);
endtask

// Clears the lists and holds reset for 4 cycles
task automatic beginTest(string name);
    currentTest = name;
    prog.delete();
    expReg.delete();
    expData.delete();
    gotReg.delete();
    gotData.delete();
    @(negedge idex);
    rstN   = 1'b0;
    progWe = 1'b0;
    start  = 1'b0;
    repeat (4) @(negedge idex);
    rstN = 1'b1;
endtask

// One word per clock through the load port
task automatic loadProgram();
    for (int i = 0; i < prog.size(); i++) begin
        progWe   = 1'b1;
        progAddr = i[$clog2(IMEM_DEPTH)-1:0];
        progData = prog[i];
        @(negedge idex);
    end
    progWe = 1'b0;
endtask

// Start pulse and then log write-backs until halted
task automatic startAndCollect();
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    start  = 1'b1;
    @(negedge idex);
    start = 1'b0;
    while (!done && cycles < RUN_LIMIT) begin
        @(negedge idex);
        cycles++;
        if (wbValid) begin
            gotReg.push_back(wbReg);
            gotData.push_back(wbData);
            if (halted) begin
                numErrors++;
                $display("Test %s retired a write-back in the cycle halted rose",
                         currentTest);
            end
        end
        if (halted) begin
            done = 1'b1;
        end
    end
    if (!done) begin
        numErrors++;
        $display("Test %s did not halt within %0d cycles", currentTest, RUN_LIMIT);
    end else begin
        // Nothing may retire once halted
        repeat (POST_HALT) begin
            @(negedge idex);
            if (wbValid) begin
                numErrors++;
                $display("Test %s saw a write-back to r%0d after halted",
                         currentTest, wbReg);
            end
        end
    end
endtask

task automatic runProgram();
    int n;
    loadProgram();
    checkHalted(1'b0);
    startAndCollect();
    checkCount(expReg.size(), gotReg.size());
    n = (gotReg.size() < expReg.size()) ? gotReg.size() : expReg.size();
    for (int i = 0; i < n; i++) begin
        checkWb(expReg[i], expData[i], gotReg[i], gotData[i], i);
    end
    checkHalted(1'b1);
endtask

// Back-to-back dependencies over both forwarding paths
task automatic arithChain();
    wordT a;
    wordT b;
    wordT c;
    wordT d;
    wordT h;
    beginTest("arith chain");
    a = 32'd6;
    b = a + 32'd7;
    c = a + b;
    d = c - a;
    h = 32'hffff_fffd;
    prog.push_back(encI(opAddi, 0, 1, 16'd6));
    prog.push_back(encI(opAddi, 1, 2, 16'd7));
    prog.push_back(encR(fnAdd, 1, 2, 3, 0));
    prog.push_back(encR(fnSub, 3, 1, 4, 0));
    prog.push_back(encR(fnAnd, 3, 2, 5, 0));
    prog.push_back(encR(fnOr, 5, 4, 6, 0));
    prog.push_back(encR(fnSlt, 3, 4, 7, 0));
    prog.push_back(encI(opAddi, 0, 8, 16'hfffd));
    prog.push_back(encR(fnSlt, 8, 1, 9, 0));
    prog.push_back(encR(fnSll, 0, 2, 10, 5'd4));
    prog.push_back(HALT_WORD);
    expectWb(1, a);
    expectWb(2, b);
    expectWb(3, c);
    expectWb(4, d);
    expectWb(5, c & b);
    expectWb(6, (c & b) | d);
    expectWb(7, ($signed(c) < $signed(d)) ? 32'd1 : 32'd0);
    expectWb(8, h);
    expectWb(9, ($signed(h) < $signed(a)) ? 32'd1 : 32'd0);
    expectWb(10, b << 4);
    runProgram();
endtask

// Store, reload, and use the load at once on rs and on rt
task automatic storeLoadUse();
    wordT addr;
    wordT val;
    beginTest("store and load-use");
    addr = 32'd9;
    val  = 32'h1234;
    prog.push_back(encI(opAddi, 0, 1, 16'd9));
    prog.push_back(encI(opAddi, 0, 2, 16'h1234));
    prog.push_back(encI(opSw, 1, 2, 16'd3));
    prog.push_back(encI(opLw, 1, 3, 16'd3));
    prog.push_back(encR(fnAdd, 3, 2, 4, 0));
    prog.push_back(encI(opLw, 1, 5, 16'd3));
    prog.push_back(encR(fnAdd, 1, 5, 6, 0));
    prog.push_back(HALT_WORD);
    expectWb(1, addr);
    expectWb(2, val);
    expectWb(3, val);
    expectWb(4, val + val);
    expectWb(5, val);
    expectWb(6, addr + val);
    runProgram();
endtask

// Taken beq and bne squash two and a not-taken bne falls through
task automatic branchFlush();
    beginTest("branches");
    prog.push_back(encI(opAddi, 0, 1, 16'd4));
    prog.push_back(encI(opAddi, 0, 2, 16'd4));
    // Target 3 + 2 = 5
    prog.push_back(encI(opBeq, 1, 2, 16'd2));
    prog.push_back(encI(opAddi, 0, 3, 16'd111));
    prog.push_back(encI(opAddi, 0, 4, 16'd222));
    prog.push_back(encI(opAddi, 0, 5, 16'd55));
    prog.push_back(encI(opBne, 1, 2, 16'd3));
    prog.push_back(encI(opAddi, 0, 6, 16'd66));
    // Target 9 + 2 = 11
    prog.push_back(encI(opBne, 1, 5, 16'd2));
    prog.push_back(encI(opAddi, 0, 7, 16'd77));
    prog.push_back(encI(opAddi, 0, 9, 16'd99));
    prog.push_back(encI(opAddi, 0, 8, 16'd88));
    prog.push_back(HALT_WORD);
    expectWb(1, 32'd4);
    expectWb(2, 32'd4);
    expectWb(5, 32'd55);
    expectWb(6, 32'd66);
    expectWb(8, 32'd88);
    runProgram();
endtask

// r0 stays zero and stays silent; nothing after halt retires
task automatic haltAndZero();
    beginTest("halt and r0");
    prog.push_back(encI(opAddi, 0, 0, 16'd25));
    prog.push_back(encI(opAddi, 0, 1, 16'd7));
    prog.push_back(encR(fnAdd, 0, 1, 2, 0));
    prog.push_back(encR(fnOr, 0, 0, 3, 0));
    prog.push_back(HALT_WORD);
    prog.push_back(encI(opAddi, 0, 4, 16'd1));
    prog.push_back(encI(opAddi, 0, 5, 16'd2));
    expectWb(1, 32'd7);
    expectWb(2, 32'd7);
    expectWb(3, 32'd0);
    runProgram();
endtask

// Seeded immediates with the running sum rotated over r1..r5
task automatic randomAddiChain();
    wordT        sum;
    logic [15:0] imm;
    regIdxT      dst;
    regIdxT      src;
    beginTest("random addi chain");
    sum = '0;
    src = '0;
    for (int k = 0; k < 12; k++) begin
        imm = 16'($random(seed));
        dst = regIdxT'(1 + (k % 5));
        prog.push_back(encI(opAddi, src, dst, imm));
        sum = sum + {{16{imm[15]}}, imm};
        expectWb(dst, sum);
        src = dst;
    end
    prog.push_back(HALT_WORD);
    runProgram();
endtask

`endif

// ==== sim/cpuTb.sv ====
`default_nettype none

module cpuTb import cpuIsaPkg::*; ();

    localparam int IMEM_DEPTH   = 64;
    localparam int DMEM_DEPTH   = 64;
    localparam int DRAIN_CYCLES = 3;
    localparam int NUM_TESTS    = 5;
    // Whole-run budget in clock cycles
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 300;
    // Per-program limit while waiting for halted
    localparam int RUN_LIMIT = 200;
    // Quiet window watched after halted
    localparam int POST_HALT = 10;

    // DUT inputs
    logic                          idex;
    logic                          rstN;
    logic                          progWe;
    logic [$clog2(IMEM_DEPTH)-1:0] progAddr;
    wordT                          progData;
    logic                          start;

    // DUT outputs
    logic   wbValid;
    regIdxT wbReg;
    wordT   wbData;
    logic   halted;

    // Bookkeeping
    int     numChecks;
    int     numErrors;
    integer seed;
    string  currentTest;

    // Program image and write-back lists
    wordT   prog [$];
    regIdxT expReg [$];
    wordT   expData [$];
    regIdxT gotReg [$];
    wordT   gotData [$];

    cpuTop #(
        .IMEM_DEPTH   (IMEM_DEPTH),
        .DMEM_DEPTH   (DMEM_DEPTH),
        .DRAIN_CYCLES (DRAIN_CYCLES)
    ) cpuTop_i (
        .idex     (idex),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .start    (start),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .halted   (halted)
    );

    initial begin
        idex = 1'b0;
        forever begin
            #5 idex = ~idex;
        end
    end

    // Ends a hung run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge idex);
        $display("Watchdog expired after %0d cycles, test %s stalled",
                 WATCHDOG_CYCLES, currentTest);
        $display("sim failed");
        $finish;
    end

    // One retired write-back against its expected entry
    task automatic checkWb(regIdxT wantReg, wordT wantData, regIdxT haveReg,
                           wordT haveData, int idx);
        numChecks++;
        if (haveReg !== wantReg || haveData !== wantData) begin
            numErrors++;
            $display("** Error at %0t: %s write-back %0d expected r%0d = %h, got r%0d = %h",
                     $time, currentTest, idx, wantReg, wantData, haveReg, haveData);
        end
    endtask

    task automatic checkHalted(logic want);
        numChecks++;
        if (halted !== want) begin
            numErrors++;
            $display("** Error at %0t: %s halted expected %b, got %b",
                     $time, currentTest, want, halted);
        end
    endtask

    task automatic checkCount(int want, int have);
        numChecks++;
        if (have != want) begin
            numErrors++;
            $display("** Error at %0t: %s expected %0d write-backs, got %0d",
                     $time, currentTest, want, have);
        end
    endtask

    `include "cpuTests.svh"

    initial begin
        rstN        = 1'b0;
        progWe      = 1'b0;
        progAddr    = '0;
        progData    = '0;
        start       = 1'b0;
        numChecks   = 0;
        numErrors   = 0;
        seed        = 32'hd76c;
        currentTest = "none";

        arithChain();
        storeLoadUse();
        branchFlush();
        haltAndZero();
        randomAddiChain();

        $display("Run complete: %0d checks, %0d errors", numChecks, numErrors);
        if (numErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+sim
hdl/cpuIsaPkg.sv
hdl/cpuPipePkg.sv
hdl/drainTimer.sv
hdl/runControl.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/cpuTop.sv
sim/cpuTb.sv
